//--- Bender.yml
package:
  name: id_stage

export_include_dirs:
  - src

sources:
  - src/id_stage_pkg.sv
  - src/inst_decoder.sv
  - src/id_pipe_reg.sv
  - src/issue_queue.sv
  - src/id_stage_top.sv
  - target: test
    files:
      - test/id_stage_assertions.sv
      - test/id_stage_tb.sv

//--- id_stage_top.f
+incdir+src
src/id_stage_pkg.sv
src/inst_decoder.sv
src/id_pipe_reg.sv
src/issue_queue.sv
src/id_stage_top.sv
test/id_stage_assertions.sv
test/id_stage_tb.sv

//--- src/id_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_pipe_reg
    import id_stage_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      flush,

    // decode side.
    input  logic      id_readygo,
    output logic      id_allowin,
    input  dec_pair_t in_pair,

    // issue queue side.
    input  logic      reg_allowin,
    output logic      reg_readygo,
    output dec_pair_t reg_pair
);

    logic      valid_q;
    dec_pair_t pair_q;
    logic      load;

    // room when empty, or when the held pair leaves this cycle.
    assign id_allowin = ~valid_q | reg_allowin;
    assign load       = id_readygo & id_allowin;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (reg_allowin) begin
            // held pair moved on with nothing behind it.
            valid_q <= 1'b0;
        end
    end

    // payload only, contents are don't-care while invalid.
    always_ff @(posedge aclk) begin
        if (load) begin
            pair_q <= in_pair;
        end
    end

    assign reg_readygo = valid_q;
    assign reg_pair    = pair_q;

endmodule

`default_nettype wire

//--- src/id_stage_cfg.svh
`ifndef ID_STAGE_CFG_SVH
`define ID_STAGE_CFG_SVH

// micro-op code width.
`define ID_UOP_WIDTH 8

// decoded pairs held by the issue queue.
`define ID_IQ_DEPTH 4

// addi r0, r0, 0.
`define ID_INST_NOP 32'h2000_0000

// instruction field positions.
`define ID_OP_MSB 31
`define ID_OP_LSB 26
`define ID_RD_MSB 4
`define ID_RD_LSB 0
`define ID_RJ_MSB 9
`define ID_RJ_LSB 5
`define ID_RK_MSB 14
`define ID_RK_LSB 10
`define ID_IMM_LSB 10
`define ID_IMM12_MSB 21
`define ID_CSR14_MSB 23
`define ID_OFFS16_MSB 25

`endif

//--- src/id_stage_pkg.sv
`default_nettype none

`include "id_stage_cfg.svh"

package id_stage_pkg;

    typedef enum logic [5:0] {
        OP_ADD     = 6'h01,
        OP_SUB     = 6'h02,
        OP_AND     = 6'h03,
        OP_OR      = 6'h04,
        OP_ADDI    = 6'h08,
        OP_ORI     = 6'h09,
        OP_LD      = 6'h0a,
        OP_ST      = 6'h0b,
        OP_BEQ     = 6'h10,
        OP_BNE     = 6'h11,
        OP_SYSCALL = 6'h18,
        OP_BREAK   = 6'h19,
        OP_CSRRD   = 6'h1c,
        OP_CSRWR   = 6'h1d
    } opcode_e;

    typedef enum logic [`ID_UOP_WIDTH-1:0] {
        UOP_NOP, UOP_ADD, UOP_SUB, UOP_AND, UOP_OR, UOP_ADDI, UOP_ORI,
        UOP_LD, UOP_ST, UOP_BEQ, UOP_BNE, UOP_SYSCALL, UOP_BREAK,
        UOP_CSRRD, UOP_CSRWR
    } uop_e;

    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ADEF = 7'h08,
        EXC_INE  = 7'h0d,
        EXC_TLBR = 7'h3f
    } exc_code_e;

    typedef struct packed {
        logic [31:0] pc0;
        logic [31:0] pc1;
        logic [31:0] pc_next;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] badv;
        logic        fetch_excp;
        exc_code_e   fetch_exc_code;
        // predicted-taken marker, passed through untouched.
        logic        branch_flag;
    } fetch_pair_t;

    typedef struct packed {
        logic        is_alu;
        logic        is_syscall;
        logic        is_break;
        logic        is_priv;
        uop_e        uop;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic        excp;
        exc_code_e   exc_code;
    } dec_slot_t;

    typedef struct packed {
        fetch_pair_t fetch;
        dec_slot_t   slot0;
        dec_slot_t   slot1;
    } dec_pair_t;

endpackage

`default_nettype wire

//--- src/id_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_top
    import id_stage_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n,
    input  logic        flush,

    // fetch buffer side.
    input  logic        fetch_valid,
    input  fetch_pair_t fetch_pair,
    output logic        fetch_allowin,

    // issue side.
    output logic        issue_valid,
    output dec_pair_t   issue_pair,
    input  logic        issue_allowin
);

    dec_slot_t slot0;
    dec_slot_t slot1;
    dec_pair_t dec_pair;
    dec_pair_t reg_pair;
    logic      reg_readygo;
    logic      reg_allowin;

    inst_decoder u_dec0 (
        .inst           (fetch_pair.inst0),
        .fetch_excp     (fetch_pair.fetch_excp),
        .fetch_exc_code (fetch_pair.fetch_exc_code),
        .slot           (slot0)
    );

    inst_decoder u_dec1 (
        .inst           (fetch_pair.inst1),
        .fetch_excp     (fetch_pair.fetch_excp),
        .fetch_exc_code (fetch_pair.fetch_exc_code),
        .slot           (slot1)
    );

    assign dec_pair = '{fetch: fetch_pair, slot0: slot0, slot1: slot1};

    id_pipe_reg u_pipe (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .flush       (flush),
        .id_readygo  (fetch_valid),
        .id_allowin  (fetch_allowin),
        .in_pair     (dec_pair),
        .reg_allowin (reg_allowin),
        .reg_readygo (reg_readygo),
        .reg_pair    (reg_pair)
    );

    issue_queue u_iq (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .flush         (flush),
        .reg_readygo   (reg_readygo),
        .reg_pair      (reg_pair),
        .reg_allowin   (reg_allowin),
        .issue_valid   (issue_valid),
        .issue_pair    (issue_pair),
        .issue_allowin (issue_allowin)
    );

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_stage_cfg.svh"

module inst_decoder
    import id_stage_pkg::*;
(
    input  logic [31:0] inst,
    input  logic        fetch_excp,
    input  exc_code_e   fetch_exc_code,
    output dec_slot_t   slot
);

    opcode_e     op;
    logic [31:0] imm_s12;
    logic [31:0] imm_u12;
    logic [31:0] imm_br;
    logic [31:0] imm_csr;
    logic        illegal;

    assign op = opcode_e'(inst[`ID_OP_MSB:`ID_OP_LSB]);

    // immediate candidates, one per instruction class.
    assign imm_s12 = {{20{inst[`ID_IMM12_MSB]}}, inst[`ID_IMM12_MSB:`ID_IMM_LSB]};
    assign imm_u12 = {20'd0, inst[`ID_IMM12_MSB:`ID_IMM_LSB]};
    assign imm_br  = {{14{inst[`ID_OFFS16_MSB]}}, inst[`ID_OFFS16_MSB:`ID_IMM_LSB], 2'b00};
    assign imm_csr = {18'd0, inst[`ID_CSR14_MSB:`ID_IMM_LSB]};

    always_comb begin
        slot          = '0;
        slot.uop      = UOP_NOP;
        slot.exc_code = EXC_NONE;
        slot.rd       = inst[`ID_RD_MSB:`ID_RD_LSB];
        slot.rj       = inst[`ID_RJ_MSB:`ID_RJ_LSB];
        slot.rk       = inst[`ID_RK_MSB:`ID_RK_LSB];
        illegal       = 1'b0;

        case (op)
            OP_ADD: begin
                slot.is_alu = 1'b1;
                slot.uop    = UOP_ADD;
            end
            OP_SUB: begin
                slot.is_alu = 1'b1;
                slot.uop    = UOP_SUB;
            end
            OP_AND: begin
                slot.is_alu = 1'b1;
                slot.uop    = UOP_AND;
            end
            OP_OR: begin
                slot.is_alu = 1'b1;
                slot.uop    = UOP_OR;
            end
            OP_ADDI: begin
                slot.is_alu = 1'b1;
                slot.uop    = UOP_ADDI;
                slot.imm    = imm_s12;
            end
            OP_ORI: begin
                slot.is_alu = 1'b1;
                slot.uop    = UOP_ORI;
                slot.imm    = imm_u12;
            end
            OP_LD: begin
                slot.uop = UOP_LD;
                slot.imm = imm_s12;
            end
            OP_ST: begin
                slot.uop = UOP_ST;
                slot.imm = imm_s12;
            end
            OP_BEQ: begin
                slot.uop = UOP_BEQ;
                slot.imm = imm_br;
            end
            OP_BNE: begin
                slot.uop = UOP_BNE;
                slot.imm = imm_br;
            end
            OP_SYSCALL: begin
                slot.is_syscall = 1'b1;
                slot.uop        = UOP_SYSCALL;
            end
            OP_BREAK: begin
                slot.is_break = 1'b1;
                slot.uop      = UOP_BREAK;
            end
            OP_CSRRD: begin
                slot.is_priv = 1'b1;
                slot.uop     = UOP_CSRRD;
                slot.imm     = imm_csr;
            end
            OP_CSRWR: begin
                slot.is_priv = 1'b1;
                slot.uop     = UOP_CSRWR;
                slot.imm     = imm_csr;
            end
            default: illegal = 1'b1;
        endcase

        // a fetch fault wins over an illegal opcode.
        if (fetch_excp) begin
            slot.excp     = 1'b1;
            slot.exc_code = fetch_exc_code;
        end else if (illegal) begin
            slot.excp     = 1'b1;
            slot.exc_code = EXC_INE;
        end
    end

endmodule

`default_nettype wire

//--- src/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_stage_cfg.svh"

module issue_queue
    import id_stage_pkg::*;
#(
    parameter int DEPTH = `ID_IQ_DEPTH
) (
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      flush,

    // pipeline register side.
    input  logic      reg_readygo,
    input  dec_pair_t reg_pair,
    output logic      reg_allowin,

    // issue side.
    output logic      issue_valid,
    output dec_pair_t issue_pair,
    input  logic      issue_allowin
);

    localparam int PTR_W = $clog2(DEPTH);

    dec_pair_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == (PTR_W+1)'(DEPTH));
    assign pop  = issue_valid & issue_allowin;

    // a full queue still takes a pair when the head leaves.
    assign reg_allowin = ~full | pop;
    assign push        = reg_readygo & reg_allowin;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage, no reset.
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= reg_pair;
        end
    end

    // head comes straight from the storage registers.
    assign issue_valid = (count != '0);
    assign issue_pair  = mem[rd_ptr];

endmodule

`default_nettype wire

//--- test/id_stage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_assertions
    import id_stage_pkg::*;
(
    input logic      aclk,
    input logic      rst_n,
    input logic      flush,
    input logic      fetch_allowin,
    input logic      issue_valid,
    input dec_pair_t issue_pair,
    input logic      issue_allowin
);

    // number of failed assertions.
    int assert_errors = 0;

    reset_idle: assert property (@(posedge aclk) !rst_n |-> !issue_valid && fetch_allowin)
        else begin
            $error("issue port busy or fetch blocked during reset");
            assert_errors++;
        end

    // a stalled head must not move.
    head_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        issue_valid && !issue_allowin && !flush |=> issue_valid && $stable(issue_pair))
        else begin
            $error("issue head changed while stalled");
            assert_errors++;
        end

    flush_empty: assert property (@(posedge aclk) disable iff (!rst_n)
        flush |=> !issue_valid)
        else begin
            $error("issue_valid still high after flush");
            assert_errors++;
        end

    // an empty or draining queue never stalls the fetch side.
    fetch_room: assert property (@(posedge aclk) disable iff (!rst_n)
        (!issue_valid || issue_allowin) |-> fetch_allowin)
        else begin
            $error("fetch blocked although the issue queue has room");
            assert_errors++;
        end

endmodule

`default_nettype wire

//--- test/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_stage_cfg.svh"

module id_stage_tb
    import id_stage_pkg::*;
();

    localparam int RAND_CYCLES     = 2000;
    localparam int DIRECTED_CYCLES = 200;
    localparam int TIMEOUT_CYCLES  = 4 * (RAND_CYCLES + DIRECTED_CYCLES);
    localparam logic [5:0] LEGAL_OPS [14] = '{
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_ORI, OP_LD, OP_ST,
        OP_BEQ, OP_BNE, OP_SYSCALL, OP_BREAK, OP_CSRRD, OP_CSRWR
    };

    logic        aclk;
    logic        rst_n;
    logic        flush;
    logic        fetch_valid;
    fetch_pair_t fetch_pair;
    logic        fetch_allowin;
    logic        issue_valid;
    dec_pair_t   issue_pair;
    logic        issue_allowin;

    logic [31:0] rng;
    dec_pair_t   sb [$];
    int          lat_q [$];
    logic        fetch_taken = 1'b0;
    logic        lat_check = 1'b0;
    int          cycle = 0;
    int          timer = 0;
    int          checks = 0;
    int          errors = 0;
    int          accepted = 0;
    int          issued = 0;

    id_stage_top dut0 (.*);

    bind id_stage_top id_stage_assertions u_asrt (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        timer++;
        if (timer >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the pipeline stopped draining", timer);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // about one in ten opcodes lands in the unused upper half.
    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [31:0] s;
        r = xorshift32();
        s = xorshift32();
        if (s[31:24] < 8'd26) begin
            return {1'b1, s[4:0], r[25:0]};
        end
        return {LEGAL_OPS[s[15:0] % 14], r[25:0]};
    endfunction

    function automatic fetch_pair_t random_pair();
        fetch_pair_t p;
        logic [31:0] r;
        p.pc0     = xorshift32() & 32'hffff_fffc;
        p.pc1     = p.pc0 + 32'd4;
        p.pc_next = p.pc0 + 32'd8;
        p.inst0   = random_inst();
        p.inst1   = random_inst();
        p.badv    = xorshift32();
        r         = xorshift32();
        p.fetch_excp     = (r[7:0] < 8'd13);
        p.fetch_exc_code = p.fetch_excp ? (r[8] ? EXC_ADEF : EXC_TLBR) : EXC_NONE;
        p.branch_flag    = r[9];
        return p;
    endfunction

    function automatic dec_slot_t expected_slot(logic [31:0] inst, logic fexcp,
                                                exc_code_e fcode);
        dec_slot_t  s;
        logic [5:0] op;
        op         = inst[31:26];
        s          = '0;
        s.uop      = UOP_NOP;
        s.exc_code = EXC_NONE;
        s.rd       = inst[4:0];
        s.rj       = inst[9:5];
        s.rk       = inst[14:10];
        for (int i = 0; i < 14; i++) begin
            if (op == LEGAL_OPS[i]) begin
                s.uop = uop_e'(i + 1);
            end
        end
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR: s.is_alu = 1'b1;
            OP_ADDI: begin
                s.is_alu = 1'b1;
                s.imm    = 32'($signed(inst[21:10]));
            end
            OP_ORI: begin
                s.is_alu = 1'b1;
                s.imm    = {20'd0, inst[21:10]};
            end
            OP_LD, OP_ST: s.imm = 32'($signed(inst[21:10]));
            OP_BEQ, OP_BNE: s.imm = 32'($signed(inst[25:10])) << 2;
            OP_SYSCALL: s.is_syscall = 1'b1;
            OP_BREAK: s.is_break = 1'b1;
            OP_CSRRD, OP_CSRWR: begin
                s.is_priv = 1'b1;
                s.imm     = {18'd0, inst[23:10]};
            end
            default: begin
                s.excp     = 1'b1;
                s.exc_code = EXC_INE;
            end
        endcase
        if (fexcp) begin
            s.excp     = 1'b1;
            s.exc_code = fcode;
        end
        return s;
    endfunction

    function automatic dec_pair_t expected_pair(fetch_pair_t f);
        dec_pair_t d;
        d.fetch = f;
        d.slot0 = expected_slot(f.inst0, f.fetch_excp, f.fetch_exc_code);
        d.slot1 = expected_slot(f.inst1, f.fetch_excp, f.fetch_exc_code);
        return d;
    endfunction

    task automatic check_value(input string name, input logic [255:0] exp,
                               input logic [255:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic compare_pair(input dec_pair_t exp, input dec_pair_t act);
        dec_slot_t e;
        dec_slot_t a;
        check_value("fetch", exp.fetch, act.fetch);
        for (int i = 0; i < 2; i++) begin
            e = (i == 0) ? exp.slot0 : exp.slot1;
            a = (i == 0) ? act.slot0 : act.slot1;
            check_value($sformatf("slot%0d.flags", i),
                        {e.is_alu, e.is_syscall, e.is_break, e.is_priv},
                        {a.is_alu, a.is_syscall, a.is_break, a.is_priv});
            check_value($sformatf("slot%0d.uop", i), e.uop, a.uop);
            check_value($sformatf("slot%0d.imm", i), e.imm, a.imm);
            check_value($sformatf("slot%0d.rd_rj_rk", i), {e.rd, e.rj, e.rk}, {a.rd, a.rj, a.rk});
            check_value($sformatf("slot%0d.excp", i), e.excp, a.excp);
            check_value($sformatf("slot%0d.exc_code", i), e.exc_code, a.exc_code);
        end
    endtask

    // inputs are stable here, so these are the handshakes of the coming edge.
    always @(negedge aclk) begin
        dec_pair_t exp;
        int        fcyc;
        if (rst_n) begin
            cycle++;
            fetch_taken = fetch_valid && fetch_allowin;
            if (issue_valid && issue_allowin) begin
                if (sb.size() == 0) begin
                    errors++;
                    $display("pair issued at cycle %0d with none outstanding", cycle);
                end else begin
                    exp  = sb.pop_front();
                    fcyc = lat_q.pop_front();
                    compare_pair(exp, issue_pair);
                    issued++;
                    if (lat_check && (cycle - fcyc != 2)) begin
                        errors++;
                        $display("pair took %0d cycles from fetch to issue", cycle - fcyc);
                    end
                end
            end
            if (flush) begin
                sb.delete();
                lat_q.delete();
            end else if (fetch_taken) begin
                sb.push_back(expected_pair(fetch_pair));
                lat_q.push_back(cycle);
                accepted++;
            end
        end
    end

    // a pair that is offered but not taken stays on the fetch port.
    task automatic drive_cycle(input logic valid, input logic allow, input logic flsh);
        @(posedge aclk);
        #1;
        if (!fetch_valid || fetch_taken) begin
            fetch_valid = valid;
            fetch_pair  = random_pair();
        end
        issue_allowin = allow;
        flush         = flsh;
    endtask

    // the register empties into the queue within a cycle, so two idle looks mean all is out.
    task automatic drain();
        int idle;
        idle = 0;
        while (idle < 2) begin
            drive_cycle(1'b0, 1'b1, 1'b0);
            if (fetch_valid || issue_valid) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        logic        flsh;
        int          base;
        rng           = 32'd76;
        rst_n         = 1'b0;
        flush         = 1'b0;
        fetch_valid   = 1'b0;
        fetch_pair    = '0;
        issue_allowin = 1'b0;
        repeat (10) @(posedge aclk);
        #1 rst_n = 1'b1;
        #2;
        check_value("issue_valid", 1'b0, issue_valid);
        check_value("fetch_allowin", 1'b1, fetch_allowin);

        // single pairs through an empty pipe.
        lat_check = 1'b1;
        repeat (3) begin
            drive_cycle(1'b1, 1'b1, 1'b0);
            drain();
        end
        lat_check = 1'b0;

        // stalled consumer fills the queue and the register.
        base = accepted;
        repeat (12) drive_cycle(1'b1, 1'b0, 1'b0);
        #2;
        check_value("fetch_allowin", 1'b0, fetch_allowin);
        check_value("accepted", `ID_IQ_DEPTH + 1, accepted - base);
        drain();

        // flush drops everything in flight.
        repeat (3) drive_cycle(1'b1, 1'b0, 1'b0);
        drive_cycle(1'b0, 1'b0, 1'b1);
        drive_cycle(1'b0, 1'b1, 1'b0);
        #2;
        check_value("issue_valid", 1'b0, issue_valid);
        repeat (4) drive_cycle(1'b1, 1'b1, 1'b0);
        drain();

        repeat (RAND_CYCLES) begin
            r    = xorshift32();
            flsh = (r[23:16] < 8'd3);
            drive_cycle(r[7:0] < 8'd179, (r[15:8] < 8'd154) && !flsh, flsh);
        end
        drain();

        if (sb.size() != 0) begin
            errors++;
            $display("%0d accepted pairs were never issued", sb.size());
        end
        $display("checks %0d, errors %0d, assertion errors %0d, accepted %0d, issued %0d",
                 checks, errors, dut0.u_asrt.assert_errors, accepted, issued);
        if (errors == 0 && dut0.u_asrt.assert_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
